//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FME-7 testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ns \
	--top-module fme7_tb \
	-f tb.f \
	-o fme7_sim

# The testbench ends every failing run with $fatal, so the exit status carries the result
./obj_dir/fme7_sim +verilator+error+limit+1000

//--- tb.f
verilog/fme7_pkg.sv
verilog/fme7_regs.sv
verilog/fme7_irq.sv
verilog/fme7_addr_map.sv
verilog/fme7_mapper.sv
verification/fme7_assertions.sv
verification/fme7_tb.sv

//--- verification/fme7_assertions.sv
// Checker for the FME-7 mapper, bound to the top level and driven only by its ports
module fme7_assertions (
	input logic                clk,
	input logic                rst,
	input logic                ce,
	input fme7_pkg::cpu_addr_t prg_ain,
	input logic                prg_write,
	input fme7_pkg::cpu_data_t prg_din,
	input fme7_pkg::ppu_addr_t chr_ain,
	input fme7_pkg::rom_addr_t prg_aout,
	input logic                prg_allow,
	input fme7_pkg::rom_addr_t chr_aout,
	input logic                vram_a10,
	input logic                vram_ce,
	input logic                irq
);

	timeunit 1ns;
	timeprecision 1ns;

	import fme7_pkg::*;

	int              fail_count = 0;   // Read by the testbench
	cmd_t            sh_cmd;
	chr_bank_t [7:0] sh_chr;
	prg_bank_t [3:0] sh_prg;
	mirror_t         sh_mirror;
	logic            sh_ram_en;
	logic            sh_ram_sel;
	logic            sh_countdown;
	logic            sh_trigger;
	irq_count_t      sh_count;
	logic            sh_irq;
	logic            wr_cmd;
	logic            wr_param;
	prg_bank_t       exp_bank;
	logic            exp_ram_cs;
	rom_addr_t       exp_prg;
	logic            exp_allow;
	rom_addr_t       exp_chr;
	logic            exp_a10;

	assign wr_cmd   = ce && prg_write && prg_ain[15] && (prg_ain[14:13] == 2'd0);
	assign wr_param = ce && prg_write && prg_ain[15] && (prg_ain[14:13] == 2'd1);

	always_comb begin
		case (prg_ain[15:13])
			3'd3:    exp_bank = sh_prg[0];
			3'd4:    exp_bank = sh_prg[1];
			3'd5:    exp_bank = sh_prg[2];
			3'd6:    exp_bank = sh_prg[3];
			3'd7:    exp_bank = PRG_FIXED_BANK;
			default: exp_bank = '0;
		endcase
		exp_ram_cs = !prg_ain[15] && sh_ram_sel;
		exp_prg    = {1'b0, exp_ram_cs, 2'b00, exp_bank, prg_ain[12:0]};
		exp_allow  = exp_ram_cs ? sh_ram_en : !prg_write;
		exp_chr    = {CHR_ROM_TAG, sh_chr[chr_ain[12:10]], chr_ain[9:0]};
		if (sh_mirror == 2'd0) begin
			exp_a10 = chr_ain[10];
		end else if (sh_mirror == 2'd1) begin
			exp_a10 = chr_ain[11];
		end else begin
			exp_a10 = sh_mirror[0];
		end
	end

	// Register shadows, written by the bus write rule
	always_ff @(posedge clk) begin
		if (rst) begin
			sh_cmd     <= '0;
			sh_chr     <= '0;
			sh_prg     <= '0;
			sh_mirror  <= '0;
			sh_ram_en  <= 1'b0;
			sh_ram_sel <= 1'b0;
		end else begin
			if (wr_cmd) begin
				sh_cmd <= prg_din[3:0];
			end
			if (wr_param && sh_cmd <= 4'd7) begin
				sh_chr[sh_cmd[2:0]] <= prg_din;
			end
			if (wr_param && sh_cmd >= 4'd8 && sh_cmd <= 4'd11) begin
				sh_prg[sh_cmd[1:0]] <= prg_din[4:0];
			end
			if (wr_param && sh_cmd == CMD_MIRROR) begin
				sh_mirror <= prg_din[1:0];
			end
			if (wr_param && sh_cmd == CMD_PRG0) begin
				sh_ram_en  <= prg_din[7];
				sh_ram_sel <= prg_din[6];
			end
		end
	end

	// IRQ reference counter
	always_ff @(posedge clk) begin
		if (rst) begin
			sh_countdown <= 1'b0;
			sh_trigger   <= 1'b0;
			sh_count     <= '0;
			sh_irq       <= 1'b0;
		end else begin
			if (ce && sh_countdown) begin
				sh_count <= sh_count - 16'd1;
				if (sh_count == 16'd0 && sh_trigger) begin
					sh_irq <= 1'b1;   // Wrap to FFFF
				end
			end
			if (ce && !sh_trigger) begin
				sh_irq <= 1'b0;
			end
			if (wr_param && sh_cmd == CMD_IRQ_CTRL) begin
				sh_countdown <= prg_din[7];
				sh_trigger   <= prg_din[0];
			end
			if (wr_param && sh_cmd == CMD_IRQ_LO) begin
				sh_count[7:0] <= prg_din;
			end
			if (wr_param && sh_cmd == CMD_IRQ_HI) begin
				sh_count[15:8] <= prg_din;
			end
		end
	end

	a_prg_aout: assert property (@(posedge clk) disable iff (rst) prg_aout == exp_prg)
		else begin
			fail_count++;
			$error("FAIL t=%0t prg_aout got %h expected %h", $time, $sampled(prg_aout),
				$sampled(exp_prg));
		end

	a_prg_allow: assert property (@(posedge clk) disable iff (rst) prg_allow == exp_allow)
		else begin
			fail_count++;
			$error("FAIL t=%0t prg_allow got %b expected %b", $time, $sampled(prg_allow),
				$sampled(exp_allow));
		end

	a_chr_aout: assert property (@(posedge clk) disable iff (rst) chr_aout == exp_chr)
		else begin
			fail_count++;
			$error("FAIL t=%0t chr_aout got %h expected %h", $time, $sampled(chr_aout),
				$sampled(exp_chr));
		end

	a_vram_a10: assert property (@(posedge clk) disable iff (rst) vram_a10 == exp_a10)
		else begin
			fail_count++;
			$error("FAIL t=%0t vram_a10 got %b expected %b", $time, $sampled(vram_a10),
				$sampled(exp_a10));
		end

	a_vram_ce: assert property (@(posedge clk) disable iff (rst) vram_ce == chr_ain[13])
		else begin
			fail_count++;
			$error("FAIL t=%0t vram_ce got %b expected %b", $time, $sampled(vram_ce),
				$sampled(chr_ain[13]));
		end

	a_irq: assert property (@(posedge clk) disable iff (rst) irq == sh_irq)
		else begin
			fail_count++;
			$error("FAIL t=%0t irq got %b expected %b", $time, $sampled(irq), $sampled(sh_irq));
		end

endmodule

bind fme7_mapper fme7_assertions chk (
	.clk       (clk),
	.rst       (rst),
	.ce        (ce),
	.prg_ain   (prg_ain),
	.prg_write (prg_write),
	.prg_din   (prg_din),
	.chr_ain   (chr_ain),
	.prg_aout  (prg_aout),
	.prg_allow (prg_allow),
	.chr_aout  (chr_aout),
	.vram_a10  (vram_a10),
	.vram_ce   (vram_ce),
	.irq       (irq)
);

//--- verification/fme7_tb.sv
// Testbench top for the FME-7 mapper that drives bus writes and lookups for the bound checker
module fme7_tb;

	timeunit 1ns;
	timeprecision 1ns;

	import fme7_pkg::*;

	localparam int CYCLE     = 100;
	localparam int CE_BUDGET = 600;   // Upper bound on ce pulses used by all tests

	logic        clk;
	logic        rst;
	logic        ce;
	cpu_addr_t   prg_ain;
	logic        prg_write;
	cpu_data_t   prg_din;
	ppu_addr_t   chr_ain;
	rom_addr_t   prg_aout;
	logic        prg_allow;
	rom_addr_t   chr_aout;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;
	logic [1:0]  phase;
	logic [31:0] rng_state = 32'd33417;

	fme7_mapper UUT (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.chr_ain   (chr_ain),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	always #(CYCLE / 2) clk = !clk;

	// ce every fourth cycle
	always @(negedge clk) begin
		if (rst) begin
			phase <= 2'd0;
			ce    <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			ce    <= (phase == 2'd3);
		end
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic wait_ce();
		do @(posedge clk); while (!ce);
	endtask

	task automatic bus_write(input cpu_addr_t addr, input cpu_data_t data);
		@(negedge clk);
		prg_ain   = addr;
		prg_din   = data;
		prg_write = 1'b1;
		wait_ce();
		@(negedge clk);
		prg_write = 1'b0;
	endtask

	task automatic set_param(input cmd_t idx, input cpu_data_t data);
		bus_write(16'h8000, {4'h0, idx});
		bus_write(16'hA000, data);
	endtask

	task automatic lookup(input cpu_addr_t addr, input logic wr, input ppu_addr_t paddr);
		@(negedge clk);
		prg_ain   = addr;
		prg_write = wr;
		chr_ain   = paddr;
		@(posedge clk);
		@(negedge clk);
		prg_write = 1'b0;
	endtask

	// Any assertion failure ends the run at once
	always @(negedge clk) begin
		if (UUT.chk.fail_count != 0) begin
			$display("test failed");
			$fatal(1, "assertion check failed");
		end
	end

	initial begin
		#(CYCLE * (16 + CE_BUDGET * 4 + 200));
		$display("test failed");
		$fatal(1, "watchdog expired before the tests finished");
	end

	initial begin
		logic [31:0] r;
		int          n;
		logic        seen;
		clk       = 1'b0;
		rst       = 1'b1;
		ce        = 1'b0;
		prg_ain   = '0;
		prg_write = 1'b0;
		prg_din   = '0;
		chr_ain   = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst <= 1'b0;

		// Reset mapping
		for (int w = 0; w < 8; w++) begin
			lookup({w[2:0], 13'h0123}, 1'b0, {1'b0, w[2:0], 10'h155});
		end

		// PRG banking, several rounds
		for (int round = 0; round < 4; round++) begin
			for (int i = 8; i < 12; i++) begin
				r = lcg_next();
				set_param(i[3:0], r[23:16]);
			end
			for (int w = 3; w < 8; w++) begin
				r = lcg_next();
				lookup({w[2:0], r[12:0]}, 1'b0, r[29:16]);
			end
		end

		// PRG RAM window, all enable and select combinations
		for (int m = 0; m < 4; m++) begin
			r = lcg_next();
			set_param(CMD_PRG0, {m[1:0], 1'b0, r[20:16]});
			for (int k = 0; k < 4; k++) begin
				r = lcg_next();
				lookup({3'b011, r[12:0]}, r[13], r[29:16]);
				lookup({3'b010, r[12:0]}, r[14], r[29:16]);
				lookup({3'b100, r[12:0]}, 1'b0, r[29:16]);
			end
		end

		// CHR banking
		for (int i = 0; i < 8; i++) begin
			r = lcg_next();
			set_param(i[3:0], r[23:16]);
		end
		for (int k = 0; k < 16; k++) begin
			r = lcg_next();
			lookup(16'h8000, 1'b0, r[29:16]);
		end

		// Mirroring modes
		for (int m = 0; m < 4; m++) begin
			set_param(CMD_MIRROR, {6'd0, m[1:0]});
			for (int k = 0; k < 8; k++) begin
				r = lcg_next();
				lookup(16'hC000, 1'b0, r[29:16]);
			end
		end

		// IRQ counter
		r = lcg_next();
		n = int'(r[20:16]) + 2;
		set_param(CMD_IRQ_HI, 8'h00);
		set_param(CMD_IRQ_LO, cpu_data_t'(n));
		set_param(CMD_IRQ_CTRL, 8'h81);   // Countdown and trigger
		seen = 1'b0;
		for (int k = 0; k < n + 8 && !seen; k++) begin
			wait_ce();
			@(negedge clk);
			if (irq) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			$display("irq did not rise after the counter was loaded and started");
			$display("test failed");
			$fatal(1, "irq never asserted");
		end
		repeat (3) wait_ce();
		set_param(CMD_IRQ_CTRL, 8'h80);   // Drop trigger to acknowledge
		repeat (3) wait_ce();
		repeat (2) @(posedge clk);
		@(negedge clk);

		if (UUT.chk.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "assertion check failed");
		end
	end

endmodule

//--- verilog/fme7_addr_map.sv
// FME-7 address translation for PRG, PRG RAM and CHR, plus nametable mirroring
module fme7_addr_map (
	input  fme7_pkg::cpu_addr_t       prg_ain,
	input  logic                      prg_write,
	input  fme7_pkg::ppu_addr_t       chr_ain,
	input  fme7_pkg::chr_bank_t [7:0] chr_banks,
	input  fme7_pkg::prg_bank_t [3:0] prg_banks,
	input  fme7_pkg::mirror_t         mirror,
	input  logic                      ram_enable,
	input  logic                      ram_select,
	output fme7_pkg::rom_addr_t       prg_aout,
	output logic                      prg_allow,
	output fme7_pkg::rom_addr_t       chr_aout,
	output logic                      vram_a10,   // Nametable A10 line
	output logic                      vram_ce     // Route to internal VRAM
);

	import fme7_pkg::*;

	prg_bank_t prg_sel;
	chr_bank_t chr_sel;
	logic      ram_cs;

	// 8 kB PRG window select
	always_comb begin
		case (prg_ain[15:13])
			3'd3:    prg_sel = prg_banks[0];     // $6000
			3'd4:    prg_sel = prg_banks[1];     // $8000
			3'd5:    prg_sel = prg_banks[2];     // $A000
			3'd6:    prg_sel = prg_banks[3];     // $C000
			3'd7:    prg_sel = PRG_FIXED_BANK;   // $E000
			default: prg_sel = '0;
		endcase
	end

	assign ram_cs    = !prg_ain[15] && ram_select;
	assign prg_aout  = {1'b0, ram_cs, 2'b00, prg_sel, prg_ain[12:0]};
	assign prg_allow = ram_cs ? ram_enable : !prg_write;

	// 1 kB CHR slots
	assign chr_sel  = chr_banks[chr_ain[12:10]];
	assign chr_aout = {CHR_ROM_TAG, chr_sel, chr_ain[9:0]};

	always_comb begin
		case (mirror)
			2'd0:    vram_a10 = chr_ain[10];   // Vertical
			2'd1:    vram_a10 = chr_ain[11];   // Horizontal
			default: vram_a10 = mirror[0];     // One-screen lower or upper
		endcase
	end

	assign vram_ce = chr_ain[13];

endmodule

//--- verilog/fme7_irq.sv
// FME-7 CPU-cycle IRQ counter, loaded and controlled by strobes from the register port
module fme7_irq (
	input  logic                clk,
	input  logic                rst,
	input  logic                ce,           // CPU cycle enable
	input  logic                irq_ctrl_we,
	input  logic                irq_lo_we,
	input  logic                irq_hi_we,
	input  fme7_pkg::cpu_data_t wdata,
	output logic                irq
);

	import fme7_pkg::*;

	logic        countdown;   // Counter runs
	logic        trigger;     // Wrap raises irq
	irq_count_t  count;
	logic [16:0] count_next;  // Bit 16 is the borrow

	assign count_next = {1'b0, count} - {16'd0, countdown};

	always_ff @(posedge clk) begin
		if (rst) begin
			countdown <= 1'b0;
			trigger   <= 1'b0;
			count     <= '0;
			irq       <= 1'b0;
		end else begin
			if (ce) begin
				count <= count_next[15:0];
				if (trigger && count_next[16]) begin
					irq <= 1'b1;              // Wrap from 0 to FFFF
				end
				if (!trigger) begin
					irq <= 1'b0;              // Acknowledge
				end
			end

			if (irq_ctrl_we) begin
				countdown <= wdata[7];
				trigger   <= wdata[0];
			end
			// Byte loads override the decrement
			if (irq_lo_we) begin
				count[7:0] <= wdata;
			end
			if (irq_hi_we) begin
				count[15:8] <= wdata;
			end
		end
	end

endmodule

//--- verilog/fme7_mapper.sv
// Sunsoft FME-7 mapper top level, connects the register port, IRQ counter and address map
module fme7_mapper (
	input  logic                clk,
	input  logic                rst,
	input  logic                ce,          // One-cycle CPU clock enable
	input  fme7_pkg::cpu_addr_t prg_ain,
	input  logic                prg_write,
	input  fme7_pkg::cpu_data_t prg_din,
	input  fme7_pkg::ppu_addr_t chr_ain,
	output fme7_pkg::rom_addr_t prg_aout,
	output logic                prg_allow,
	output fme7_pkg::rom_addr_t chr_aout,
	output logic                vram_a10,
	output logic                vram_ce,
	output logic                irq
);

	import fme7_pkg::*;

	// Register state to the address map
	chr_bank_t [7:0] chr_banks;
	prg_bank_t [3:0] prg_banks;
	mirror_t         mirror;
	logic            ram_enable;
	logic            ram_select;

	// Write strobes to the IRQ counter
	logic            irq_ctrl_we;
	logic            irq_lo_we;
	logic            irq_hi_we;
	cpu_data_t       wdata;

	fme7_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.prg_ain     (prg_ain),
		.prg_write   (prg_write),
		.prg_din     (prg_din),
		.chr_banks   (chr_banks),
		.prg_banks   (prg_banks),
		.mirror      (mirror),
		.ram_enable  (ram_enable),
		.ram_select  (ram_select),
		.irq_ctrl_we (irq_ctrl_we),
		.irq_lo_we   (irq_lo_we),
		.irq_hi_we   (irq_hi_we),
		.wdata       (wdata)
	);

	fme7_irq u_irq (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.irq_ctrl_we (irq_ctrl_we),
		.irq_lo_we   (irq_lo_we),
		.irq_hi_we   (irq_hi_we),
		.wdata       (wdata),
		.irq         (irq)
	);

	fme7_addr_map u_addr_map (
		.prg_ain    (prg_ain),
		.prg_write  (prg_write),
		.chr_ain    (chr_ain),
		.chr_banks  (chr_banks),
		.prg_banks  (prg_banks),
		.mirror     (mirror),
		.ram_enable (ram_enable),
		.ram_select (ram_select),
		.prg_aout   (prg_aout),
		.prg_allow  (prg_allow),
		.chr_aout   (chr_aout),
		.vram_a10   (vram_a10),
		.vram_ce    (vram_ce)
	);

endmodule

//--- verilog/fme7_pkg.sv
// Types and register indices shared by the FME-7 mapper modules, imported by each of them
package fme7_pkg;

	// Bus and address widths
	typedef logic [15:0] cpu_addr_t;   // CPU address bus
	typedef logic [13:0] ppu_addr_t;   // PPU address bus
	typedef logic [21:0] rom_addr_t;   // Translated cartridge address
	typedef logic [7:0]  cpu_data_t;   // CPU data byte

	// Register contents
	typedef logic [3:0]  cmd_t;        // Parameter register index
	typedef logic [7:0]  chr_bank_t;   // 1 kB CHR bank number
	typedef logic [4:0]  prg_bank_t;   // 8 kB PRG bank number
	typedef logic [15:0] irq_count_t;  // IRQ down counter

	// Mirroring mode
	// 0 vertical, 1 horizontal, 2 one-screen lower, 3 one-screen upper
	typedef logic [1:0]  mirror_t;

	// Parameter register indices
	// Indices 0 to 7 are the CHR banks and need no name
	localparam cmd_t CMD_PRG0     = 4'd8;   // First PRG bank, also RAM control
	localparam cmd_t CMD_MIRROR   = 4'd12;  // Nametable mirroring
	localparam cmd_t CMD_IRQ_CTRL = 4'd13;  // Countdown and trigger enables
	localparam cmd_t CMD_IRQ_LO   = 4'd14;  // Counter low byte
	localparam cmd_t CMD_IRQ_HI   = 4'd15;  // Counter high byte

	// Bank hardwired into the $E000 window
	localparam prg_bank_t PRG_FIXED_BANK = 5'b11111;

	// Upper address bits that place CHR data in the ROM space
	localparam logic [3:0] CHR_ROM_TAG = 4'b1000;

endpackage

//--- verilog/fme7_regs.sv
// FME-7 command/parameter register port, holds the banking, mirroring and RAM control state
module fme7_regs (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 ce,          // CPU cycle enable
	input  fme7_pkg::cpu_addr_t                  prg_ain,
	input  logic                                 prg_write,
	input  fme7_pkg::cpu_data_t                  prg_din,
	output fme7_pkg::chr_bank_t [7:0]            chr_banks,
	output fme7_pkg::prg_bank_t [3:0]            prg_banks,   // $6000, $8000, $A000, $C000
	output fme7_pkg::mirror_t                    mirror,
	output logic                                 ram_enable,
	output logic                                 ram_select,
	output logic                                 irq_ctrl_we,
	output logic                                 irq_lo_we,
	output logic                                 irq_hi_we,
	output fme7_pkg::cpu_data_t                  wdata
);

	import fme7_pkg::*;

	cmd_t cmd;           // Selected parameter register
	logic bus_we;        // Qualified write to $8000-$FFFF
	logic cmd_we;        // Write to $8000-$9FFF
	logic param_we;      // Write to $A000-$BFFF

	assign bus_we   = ce && prg_write && prg_ain[15];
	assign cmd_we   = bus_we && (prg_ain[14:13] == 2'd0);
	assign param_we = bus_we && (prg_ain[14:13] == 2'd1);

	// IRQ registers live in the counter block, it sees the write the same edge
	assign irq_ctrl_we = param_we && (cmd == CMD_IRQ_CTRL);
	assign irq_lo_we   = param_we && (cmd == CMD_IRQ_LO);
	assign irq_hi_we   = param_we && (cmd == CMD_IRQ_HI);
	assign wdata       = prg_din;

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd        <= '0;
			chr_banks  <= '0;
			prg_banks  <= '0;
			mirror     <= '0;
			ram_enable <= 1'b0;
			ram_select <= 1'b0;
		end else begin
			if (cmd_we) begin
				cmd <= prg_din[3:0];
			end

			if (param_we) begin
				if (!cmd[3]) begin
					chr_banks[cmd[2:0]] <= prg_din;      // Indices 0-7
				end else if (cmd < CMD_MIRROR) begin
					prg_banks[cmd[1:0]] <= prg_din[4:0]; // Indices 8-11
				end else if (cmd == CMD_MIRROR) begin
					mirror <= prg_din[1:0];
				end

				// The $6000 window register also carries the RAM bits
				if (cmd == CMD_PRG0) begin
					ram_enable <= prg_din[7];
					ram_select <= prg_din[6];
				end
			end
		end
	end

endmodule
